/* rtl/fetch_pkg.sv */
package fetch_pkg;

    // Datapath width
    localparam int xlen = 32;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_vector = '0;

    // Predictor table sizes
    localparam int bht_entries = 16;
    localparam int btb_entries = 16;

    // Index widths, tables indexed from pc bit 2 upward
    localparam int bht_idx_w = $clog2(bht_entries);
    localparam int btb_idx_w = $clog2(btb_entries);

    // Tag is everything above the index
    localparam int btb_tag_w = xlen - btb_idx_w - 2;

    // Instruction memory
    localparam int imem_depth = 64;
    localparam int imem_addr_w = $clog2(imem_depth);
    localparam string imem_file = "program.hex";

    // Request payload, one per accepted pc
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            pred_taken;
        logic [xlen-1:0] pred_target;
    } fetch_req_t;

    // Request payload joined with the fetched word
    typedef struct packed {
        fetch_req_t      req;
        logic [xlen-1:0] inst;
    } fetch_out_t;

endpackage

/* rtl/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            pred_taken,
    input  logic [xlen-1:0] pred_target,
    input  logic            pc_ready,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    output logic [xlen-1:0] pc,
    output logic            pc_valid
);

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic            advance;

    assign pc_plus4 = pc + xlen'(4);

    // Current pc handed to the request register
    assign advance = pc_valid && pc_ready;

    // Redirect from execute beats any advance
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (advance && pred_taken) begin
            next_pc = pred_target;
        end else if (advance) begin
            next_pc = pc_plus4;
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= reset_vector;
            // Offer starts right away, first cycle out of reset
            pc_valid <= 1'b1;
        end else begin
            pc       <= next_pc;
        end
    end

endmodule

/* rtl/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] lookup_pc,
    output logic            pred_taken,
    output logic [xlen-1:0] pred_target,
    input  logic            update_valid,
    input  logic [xlen-1:0] update_pc,
    input  logic            update_taken,
    input  logic [xlen-1:0] update_target
);

    // 2-bit saturating counters
    logic [1:0]           bht [bht_entries];

    // Direct-mapped target buffer
    logic [btb_entries-1:0] btb_valid;
    logic [btb_tag_w-1:0]   btb_tag    [btb_entries];
    logic [xlen-1:0]        btb_target [btb_entries];

    logic [bht_idx_w-1:0] lookup_bht_idx;
    logic [btb_idx_w-1:0] lookup_btb_idx;
    logic [btb_tag_w-1:0] lookup_tag;
    logic [bht_idx_w-1:0] update_bht_idx;
    logic [btb_idx_w-1:0] update_btb_idx;
    logic [btb_tag_w-1:0] update_tag;
    logic                 btb_hit;

    assign lookup_bht_idx = lookup_pc[bht_idx_w+1:2];
    assign lookup_btb_idx = lookup_pc[btb_idx_w+1:2];
    assign lookup_tag     = lookup_pc[xlen-1:btb_idx_w+2];

    assign update_bht_idx = update_pc[bht_idx_w+1:2];
    assign update_btb_idx = update_pc[btb_idx_w+1:2];
    assign update_tag     = update_pc[xlen-1:btb_idx_w+2];

    // Lookup
    assign btb_hit = btb_valid[lookup_btb_idx]
                     && (btb_tag[lookup_btb_idx] == lookup_tag);

    // Counter MSB set means 2 or 3, i.e. taken
    assign pred_taken  = btb_hit && bht[lookup_bht_idx][1];
    assign pred_target = pred_taken ? btb_target[lookup_btb_idx]
                                    : lookup_pc + xlen'(4);

    // Counters start weakly not taken
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bht_entries; i++) begin
                bht[i] <= 2'b01;
            end
        end else if (update_valid) begin
            if (update_taken) begin
                if (bht[update_bht_idx] != 2'b11) begin
                    bht[update_bht_idx] <= bht[update_bht_idx] + 2'd1;
                end
            end else if (bht[update_bht_idx] != 2'b00) begin
                bht[update_bht_idx] <= bht[update_bht_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            btb_valid <= '0;
        end else if (update_valid && update_taken) begin
            btb_valid[update_btb_idx] <= 1'b1;
        end
    end

    // Tag and target only meaningful once the valid bit is set
    always_ff @(posedge clk) begin
        if (update_valid && update_taken) begin
            btb_tag[update_btb_idx]    <= update_tag;
            btb_target[update_btb_idx] <= update_target;
        end
    end

endmodule

/* rtl/inst_mem.sv */
`timescale 1ns/1ps

module inst_mem import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rd_en,
    input  logic [xlen-1:0] addr,
    output logic [xlen-1:0] data
);

    logic [xlen-1:0]        mem [imem_depth];
    logic [imem_addr_w-1:0] word_addr;

    initial begin
        $readmemh(imem_file, mem);
    end

    // Word addressed, byte offset dropped
    assign word_addr = addr[imem_addr_w+1:2];

    // Output holds between enabled reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data <= mem[word_addr];
        end
    end

endmodule

/* rtl/fetch_pipe_reg.sv */
`timescale 1ns/1ps

module fetch_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic load;

    // Free slot, or the current entry leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    // Resolve port from execute
    input  logic            resolve_valid,
    input  logic [xlen-1:0] resolve_pc,
    input  logic            resolve_taken,
    input  logic [xlen-1:0] resolve_target,
    input  logic            resolve_mispredict,
    // Towards decode
    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_inst,
    output logic            out_pred_taken,
    output logic [xlen-1:0] out_pred_target
);

    logic [xlen-1:0] pc;
    logic            pc_valid;
    logic            pred_taken;
    logic [xlen-1:0] pred_target;

    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    logic            req_ready;
    logic            req_valid;
    logic            out_reg_ready;
    fetch_req_t      req_in;
    fetch_req_t      req_data;
    fetch_out_t      out_in;
    fetch_out_t      out_data;

    logic [xlen-1:0] imem_data;

    // Mispredict redirects fetch and kills everything in flight
    assign redirect    = resolve_valid && resolve_mispredict;
    assign redirect_pc = resolve_taken ? resolve_target : resolve_pc + xlen'(4);

    pc_gen i_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .pc_ready    (req_ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .pc_valid    (pc_valid)
    );

    branch_predictor i_branch_predictor (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc     (pc),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .update_valid  (resolve_valid),
        .update_pc     (resolve_pc),
        .update_taken  (resolve_taken),
        .update_target (resolve_target)
    );

    // Read only when the pc moves into the request register
    inst_mem i_inst_mem (
        .clk   (clk),
        .rd_en (pc_valid && req_ready),
        .addr  (pc),
        .data  (imem_data)
    );

    assign req_in = '{pc: pc, pred_taken: pred_taken, pred_target: pred_target};

    fetch_pipe_reg #(
        .payload_t (fetch_req_t)
    ) i_req_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect),
        .in_valid  (pc_valid),
        .in_ready  (req_ready),
        .in_data   (req_in),
        .out_valid (req_valid),
        .out_ready (out_reg_ready),
        .out_data  (req_data)
    );

    // Memory word lines up with the held request
    assign out_in = '{req: req_data, inst: imem_data};

    fetch_pipe_reg #(
        .payload_t (fetch_out_t)
    ) i_out_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect),
        .in_valid  (req_valid),
        .in_ready  (out_reg_ready),
        .in_data   (out_in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    assign out_pc          = out_data.req.pc;
    assign out_inst        = out_data.inst;
    assign out_pred_taken  = out_data.req.pred_taken;
    assign out_pred_target = out_data.req.pred_target;

endmodule

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/1ps

module tb_fetch_unit import fetch_pkg::*; ();

    localparam int reset_cycles    = 16;
    localparam int random_cycles   = 4000;
    localparam int directed_cycles = 200;
    localparam int clk_period_ns   = 100;
    localparam int watchdog_ns     = (reset_cycles + random_cycles + directed_cycles)
                                     * clk_period_ns * 2;
    localparam logic [xlen-1:0] branch_pc     = 32'h0000_005c;
    localparam logic [xlen-1:0] branch_target = 32'h0000_0020;

    logic            clk = 1'b0;
    logic            rst = 1'b1;
    logic            resolve_valid = 1'b0;
    logic [xlen-1:0] resolve_pc = '0;
    logic            resolve_taken = 1'b0;
    logic [xlen-1:0] resolve_target = '0;
    logic            resolve_mispredict = 1'b0;
    logic            out_ready = 1'b1;
    logic            out_valid;
    logic [xlen-1:0] out_pc;
    logic [xlen-1:0] out_inst;
    logic            out_pred_taken;
    logic [xlen-1:0] out_pred_target;

    int seed = 19;
    int error_count = 0;
    int delivered_count = 0;
    int redirect_count = 0;

    // Reference memory and predictor tables
    logic [xlen-1:0]      model_mem [imem_depth];
    logic [1:0]           model_bht [bht_entries];
    logic                 model_btb_valid [btb_entries];
    logic [btb_tag_w-1:0] model_btb_tag [btb_entries];
    logic [xlen-1:0]      model_btb_target [btb_entries];

    // Next pc expected at the outputs
    logic [xlen-1:0] exp_pc;

    // Output stuck under back-pressure
    logic            held_valid;
    logic [xlen-1:0] held_pc;
    logic [xlen-1:0] held_inst;
    logic            held_taken;
    logic [xlen-1:0] held_target;

    // Last delivered word still waiting for a resolve
    logic            rec_valid;
    logic [xlen-1:0] rec_pc;
    logic            rec_taken;
    logic [xlen-1:0] rec_target;

    // Delivery seen in the latest cycle
    logic            del_valid;
    logic            del_taken;
    logic [xlen-1:0] del_target;

    fetch_unit i_fetch_unit (
        .clk                (clk),
        .rst                (rst),
        .resolve_valid      (resolve_valid),
        .resolve_pc         (resolve_pc),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .resolve_mispredict (resolve_mispredict),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_pc             (out_pc),
        .out_inst           (out_inst),
        .out_pred_taken     (out_pred_taken),
        .out_pred_target    (out_pred_target)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the run did not complete", watchdog_ns);
        $display("Finished with errors");
        $fatal(1, "Watchdog timeout");
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at time %0d ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < bht_entries; i++) begin
            model_bht[i]        = 2'b01;
            model_btb_valid[i]  = 1'b0;
            model_btb_tag[i]    = '0;
            model_btb_target[i] = '0;
        end
    endtask

    task automatic model_update(input logic [xlen-1:0] pc, input logic taken,
                                input logic [xlen-1:0] target);
        logic [3:0] idx;
        idx = pc[5:2];
        if (taken) begin
            if (model_bht[idx] != 2'd3)
                model_bht[idx] = model_bht[idx] + 2'd1;
            model_btb_valid[idx]  = 1'b1;
            model_btb_tag[idx]    = pc[31:6];
            model_btb_target[idx] = target;
        end else if (model_bht[idx] != 2'd0) begin
            model_bht[idx] = model_bht[idx] - 2'd1;
        end
    endtask

    task automatic model_predict(input logic [xlen-1:0] pc, output logic taken,
                                 output logic [xlen-1:0] target);
        logic [3:0] idx;
        idx = pc[5:2];
        taken = model_btb_valid[idx] && (model_btb_tag[idx] == pc[31:6])
                && (model_bht[idx] >= 2'd2);
        target = taken ? model_btb_target[idx] : pc + 32'd4;
    endtask

    // Check outputs, drive inputs on the falling edge and update the model
    task automatic run_cycle(input logic ready_in, input logic rv, input logic [xlen-1:0] rpc,
                             input logic rtaken, input logic [xlen-1:0] rtarget,
                             input logic rmis);
        logic redirect;
        redirect = rv && rmis;
        @(negedge clk);
        if (held_valid) begin
            check_equal(32'(out_valid), 32'd1, "held output dropped");
            check_equal(out_pc, held_pc, "held pc changed");
            check_equal(out_inst, held_inst, "held instruction changed");
            check_equal(32'(out_pred_taken), 32'(held_taken), "held taken flag changed");
            check_equal(out_pred_target, held_target, "held target changed");
        end
        out_ready          = ready_in;
        resolve_valid      = rv;
        resolve_pc         = rpc;
        resolve_taken      = rtaken;
        resolve_target     = rtarget;
        resolve_mispredict = rmis;
        del_valid = 1'b0;
        if (out_valid && ready_in) begin
            check_equal(out_pc, exp_pc, "delivered pc out of sequence");
            check_equal(out_inst, model_mem[out_pc[7:2]], "instruction word");
            if (!out_pred_taken)
                check_equal(out_pred_target, out_pc + 32'd4, "not-taken target");
            exp_pc     = out_pred_target;
            del_valid  = 1'b1;
            del_taken  = out_pred_taken;
            del_target = out_pred_target;
            rec_valid  = 1'b1;
            rec_pc     = out_pc;
            rec_taken  = out_pred_taken;
            rec_target = out_pred_target;
            delivered_count++;
        end
        held_valid  = out_valid && !ready_in && !redirect;
        held_pc     = out_pc;
        held_inst   = out_inst;
        held_taken  = out_pred_taken;
        held_target = out_pred_target;
        if (rv)
            model_update(rpc, rtaken, rtarget);
        // Everything in flight is dropped at the redirect edge
        if (redirect) begin
            exp_pc    = rtaken ? rtarget : rpc + 32'd4;
            rec_valid = 1'b0;
            redirect_count++;
        end
    endtask

    task automatic stall_cycles(input int n);
        repeat (n) run_cycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic train_branch(input logic [xlen-1:0] pc, input logic taken,
                                input logic [xlen-1:0] target);
        run_cycle(1'b0, 1'b1, pc, taken, target, 1'b0);
    endtask

    task automatic redirect_and_check(input logic [xlen-1:0] pc);
        logic            exp_taken;
        logic [xlen-1:0] exp_target;
        int              waited;
        // Not-taken mispredict of the word before lands fetch on pc
        run_cycle(1'b0, 1'b1, pc - 32'd4, 1'b0, '0, 1'b1);
        model_predict(pc, exp_taken, exp_target);
        waited = 0;
        del_valid = 1'b0;
        while (!del_valid) begin
            if (waited == 20) begin
                $display("No instruction delivered within 20 cycles of a redirect to %h", pc);
                $display("Finished with errors");
                $fatal(1, "Delivery timeout");
            end
            run_cycle(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
            waited++;
        end
        check_equal(32'(del_taken), 32'(exp_taken), "predicted taken flag");
        check_equal(del_target, exp_target, "predicted target");
    endtask

    initial begin
        logic [31:0]     r;
        logic            ready;
        logic            rv;
        logic [xlen-1:0] rpc;
        logic            rtaken;
        logic [xlen-1:0] rtarget;
        logic            rmis;
        int              stall_left;

        $readmemh(imem_file, model_mem);
        model_reset();
        exp_pc     = reset_vector;
        held_valid = 1'b0;
        rec_valid  = 1'b0;
        del_valid  = 1'b0;
        stall_left = 0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_equal(32'(out_valid), 32'd0, "out_valid high after reset");

        // First word reaches the outputs on the second edge
        run_cycle(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
        check_equal(32'(out_valid), 32'd0, "out_valid one cycle after reset");
        run_cycle(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
        check_equal(32'(out_valid), 32'd1, "out_valid two cycles after reset");
        check_equal(out_pc, reset_vector, "first pc after reset");

        for (int i = 0; i < random_cycles; i++) begin
            r = $random(seed);
            if (stall_left > 0) begin
                ready = 1'b0;
                stall_left--;
            end else if (r[31:26] == 6'd0) begin
                ready = 1'b0;
                stall_left = 4 + int'(r[3:0]);
            end else begin
                ready = (r % 32'd10) < 32'd7;
            end
            r = $random(seed);
            rv = 1'b0;
            rpc = '0;
            rtaken = 1'b0;
            rtarget = '0;
            rmis = 1'b0;
            if (rec_valid && r[1:0] == 2'd0) begin
                rv = 1'b1;
                rpc = rec_pc;
                // Pc bit 3 biases the outcome so counters get trained
                rtaken = rec_pc[3] ? (r[4:2] != 3'd0) : (r[4:2] == 3'd0);
                rtarget = r[5] ? {24'd0, r[13:8], 2'b00} : {24'd0, rec_pc[7:2] ^ 6'h2a, 2'b00};
                rmis = (rtaken != rec_taken) || (rtaken && rtarget != rec_target);
                rec_valid = 1'b0;
            end
            run_cycle(ready, rv, rpc, rtaken, rtarget, rmis);
        end

        // Directed predictor training on one branch
        rec_valid = 1'b0;
        stall_cycles(3);
        train_branch(branch_pc, 1'b1, branch_target);
        train_branch(branch_pc, 1'b1, branch_target);
        redirect_and_check(branch_pc);
        check_equal(32'(del_taken), 32'd1, "trained branch not predicted taken");
        check_equal(del_target, branch_target, "trained branch target");
        stall_cycles(2);
        train_branch(branch_pc, 1'b0, '0);
        redirect_and_check(branch_pc);
        stall_cycles(2);
        train_branch(branch_pc, 1'b0, '0);
        redirect_and_check(branch_pc);
        check_equal(32'(del_taken), 32'd0, "prediction kept after two not-taken updates");
        check_equal(del_target, branch_pc + 32'd4, "fall-through target");

        $display("Delivered %0d instructions across %0d redirects",
                 delivered_count, redirect_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Checks failed");
        end
    end

endmodule

/* sources.f */
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/branch_predictor.sv
rtl/inst_mem.sv
rtl/fetch_pipe_reg.sv
rtl/fetch_unit.sv
testbench/tb_fetch_unit.sv

/* run.sh */
#!/bin/sh
# Builds and runs the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module tb_fetch_unit -f sources.f

status=0
./obj_dir/Vtb_fetch_unit > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation passed"

/* program.hex */
// One 32-bit instruction word per line, word address 0 upward
// addi x1,x1,n words with a beq or bne at every eighth word
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00208863
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
fe3098e3
01108093
01208093
01308093
01408093
01508093
01608093
01708093
00408863
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
fe5098e3
02108093
02208093
02308093
02408093
02508093
02608093
02708093
00608863
02908093
02a08093
02b08093
02c08093
02d08093
02e08093
02f08093
fe7098e3
03108093
03208093
03308093
03408093
03508093
03608093
03708093
00808863
03908093
03a08093
03b08093
03c08093
03d08093
03e08093
03f08093
fe9098e3
